// ==== sim.f ====
+incdir+include
+incdir+bench
logic/cw_io_pkg.sv
logic/cw_io_regs.sv
logic/softpower_ramp.sv
logic/target_io_router.sv
logic/cw_io_top.sv
bench/tb_cw_io.sv

// ==== Makefile ====
# verilator flow for the cw_io target i/o block

TB_TOP = tb_cw_io

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module cw_io_top -f sim.f
	verilator --lint-only --timing --assert --top-module $(TB_TOP) -f sim.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f sim.f -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

// ==== bench/tb_apb_tasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// apb master side, both phases start on the falling edge
task automatic apb_write(input cw_io_pkg::apb_addr_t addr, input cw_io_pkg::apb_data_t data,
                         output logic err);
   @(negedge clk_usb);
   psel    = 1'b1;  // setup phase
   penable = 1'b0;
   pwrite  = 1'b1;
   paddr   = addr;
   pwdata  = data;
   @(negedge clk_usb);
   penable = 1'b1;  // access phase, write lands on the next rising edge
   #1;
   err = pslverr;
   @(negedge clk_usb);
   psel    = 1'b0;  // back to idle, register output already updated
   penable = 1'b0;
   pwrite  = 1'b0;
endtask

task automatic apb_read(input cw_io_pkg::apb_addr_t addr, output cw_io_pkg::apb_data_t data,
                        output logic err);
   @(negedge clk_usb);
   psel    = 1'b1;
   penable = 1'b0;
   pwrite  = 1'b0;
   paddr   = addr;
   @(negedge clk_usb);
   penable = 1'b1;
   #1;              // prdata is combinational in the access phase
   data = prdata;
   err  = pslverr;
   @(negedge clk_usb);
   psel    = 1'b0;
   penable = 1'b0;
endtask

`endif

// ==== bench/tb_cw_io.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cw_io_consts.svh"

module tb_cw_io;

   localparam int timeout_cycles = 20000;  // ramp bound plus register traffic with margin
   localparam int ramp_cycles1   = 3;
   localparam int ramp_cycles2   = 2;
   localparam int ramp_period    = 9;
   localparam int ramp_bound     = (ramp_cycles1 + ramp_cycles2 + 2) * (ramp_period + 1);
   // off_time2, off_time1, period, cycles2, cycles1 from msb down
   localparam logic [63:0] ramp_settings = {16'd2, 16'd5, 16'd9, 8'd2, 8'd3};
   localparam logic [63:0] route_reset   = `CW_IOROUTE_RESET;
   localparam logic [63:0] soft_reset    = `CW_SOFTPOWER_RESET;

   logic                 clk_usb = 1'b0;
   logic                 reset;
   logic                 psel, penable, pwrite;
   cw_io_pkg::apb_addr_t paddr;
   cw_io_pkg::apb_data_t pwdata, prdata;
   logic                 pready, pslverr;
   cw_io_pkg::targetio_t target_in, target_out, target_oe;
   logic [3:0]           target_misc;
   logic                 uart_tx, uart_rx, power_off;
   cw_io_pkg::userio_t   userio_d, trace_dir, userio_dir, userio_data;
   logic                 userio_clk, trace_en;

   int                   cycles = 0;
   logic                 err, saw_high, pwr;
   cw_io_pkg::apb_data_t rd, reg_dir;
   cw_io_pkg::apb_data_t route_wr [8];
   cw_io_pkg::apb_data_t soft_wr [8];

   cw_io_top DUT (
      .clk_usb (clk_usb), .reset (reset),
      .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
      .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
      .pready_o (pready), .pslverr_o (pslverr),
      .targetio_i (target_in), .targetio_o (target_out), .targetio_oe_o (target_oe),
      .target_misc_i (target_misc), .uart_tx_i (uart_tx), .uart_rx_o (uart_rx),
      .targetpower_off_o (power_off),
      .userio_d_i (userio_d), .userio_clk_i (userio_clk), .trace_en_i (trace_en),
      .trace_dir_i (trace_dir), .userio_dir_o (userio_dir), .userio_drive_data_o (userio_data)
   );

   always #2 clk_usb = ~clk_usb;  // 4 ns period

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("Test FAILED");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_equal(input string name, input logic [7:0] got, input logic [7:0] exp);
      assert (got === exp)
         else report_failure($sformatf("** Error: %s = 0x%02h, expected 0x%02h", name, got, exp));
   endtask

   `include "tb_apb_tasks.svh"

   task automatic write_checked(input cw_io_pkg::apb_addr_t addr, input cw_io_pkg::apb_data_t data);
      logic e;
      apb_write(addr, data, e);
      assert (!e) else report_failure($sformatf("write to 0x%02h raised pslverr", addr));
   endtask

   task automatic read_compare(input cw_io_pkg::apb_addr_t addr, input cw_io_pkg::apb_data_t exp);
      cw_io_pkg::apb_data_t d;
      logic                 e;
      apb_read(addr, d, e);
      assert (!e) else report_failure($sformatf("read of 0x%02h raised pslverr", addr));
      check_equal($sformatf("prdata_o @0x%02h", addr), d, exp);
   endtask

   // bus rules that hold on every edge
   assert property (@(posedge clk_usb) disable iff (reset) pready)
      else report_failure("pready_o dropped low");
   assert property (@(posedge clk_usb) disable iff (reset) (psel && penable) || !pslverr)
      else report_failure("pslverr_o high outside the access phase");
   assert property (@(posedge clk_usb) disable iff (reset) (psel && penable) || prdata == 8'h00)
      else report_failure("prdata_o not zero outside the access phase");

   always @(posedge clk_usb) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles)
         report_failure("timeout, the run did not finish within the cycle limit");
   end

   initial begin
      void'($urandom(12));
      reset       = 1'b1;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      paddr       = '0;
      pwdata      = '0;
      target_in   = '0;
      target_misc = '0;
      uart_tx     = 1'b1;
      userio_d    = '0;
      userio_clk  = 1'b0;
      trace_en    = 1'b0;
      trace_dir   = '0;
      repeat (8) @(posedge clk_usb);
      @(negedge clk_usb);
      reset = 1'b0;
      #1;
      check_equal("targetio_oe_o", 8'(target_oe), 8'h01);  // only gpio1 tx
      check_equal("targetpower_off_o", 8'(power_off), 8'h00);
      check_equal("pslverr_o", 8'(pslverr), 8'h00);

      // reset values byte by byte
      for (int i = 0; i < 8; i++) begin
         read_compare(`CW_ADDR_IOROUTE + 8'(i), route_reset[8*i +: 8]);
         read_compare(`CW_ADDR_SOFTPOWER + 8'(i), soft_reset[8*i +: 8]);
      end
      apb_read(8'hF0, rd, err);
      assert (err) else report_failure("read of unmapped 0xF0 gave no pslverr");
      apb_write(8'hF0, 8'h5A, err);
      assert (err) else report_failure("write to unmapped 0xF0 gave no pslverr");
      apb_write(`CW_ADDR_IOREAD, 8'h0F, err);
      assert (err) else report_failure("write to read-only IOREAD gave no pslverr");

      // random readback
      for (int i = 0; i < 8; i++) begin
         route_wr[i] = 8'($urandom);
         soft_wr[i]  = 8'($urandom);
         write_checked(`CW_ADDR_IOROUTE + 8'(i), route_wr[i]);
         write_checked(`CW_ADDR_SOFTPOWER + 8'(i), soft_wr[i]);
      end
      for (int i = 0; i < 8; i++) begin
         read_compare(`CW_ADDR_IOROUTE + 8'(i), route_wr[i]);
         read_compare(`CW_ADDR_SOFTPOWER + 8'(i), soft_wr[i]);
      end
      reg_dir = 8'($urandom);
      rd      = 8'($urandom);
      write_checked(`CW_ADDR_USERIO_DRIVEN, reg_dir);
      write_checked(`CW_ADDR_USERIO_DEBUG, rd);
      write_checked(`CW_ADDR_USERIO_DATA, ~reg_dir);
      read_compare(`CW_ADDR_USERIO_DRIVEN, reg_dir);
      read_compare(`CW_ADDR_USERIO_DEBUG, rd & 8'h07);  // three mode bits only
      read_compare(`CW_ADDR_USERIO_DATA, ~reg_dir);
      check_equal("userio_drive_data_o", userio_data, ~reg_dir);

      // sampled pins held two cycles before the read
      @(negedge clk_usb);
      target_in   = 4'($urandom);
      target_misc = 4'($urandom);
      userio_d    = 8'($urandom);
      repeat (2) @(negedge clk_usb);
      read_compare(`CW_ADDR_IOREAD, {4'h0, target_in});
      read_compare(`CW_ADDR_IOREAD + 8'd1, {4'h0, target_misc});
      read_compare(`CW_ADDR_USERIO_READ, userio_d);

      // uart routing with tx on gpio2 and gpio4 and rx on gpio3 and gpio4
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h00);  // power on
      write_checked(`CW_ADDR_IOROUTE + 8'd0, 8'h00);
      write_checked(`CW_ADDR_IOROUTE + 8'd1, 8'h01);
      write_checked(`CW_ADDR_IOROUTE + 8'd2, 8'h02);
      write_checked(`CW_ADDR_IOROUTE + 8'd3, 8'h03);
      for (int k = 0; k < 8; k++) begin
         @(negedge clk_usb);
         uart_tx   = 1'($urandom);
         target_in = 4'($urandom);
         #1;
         check_equal("targetio_oe_o", 8'(target_oe), 8'h0A);
         check_equal("targetio_o[1]", 8'(target_out[1]), 8'(uart_tx));
         check_equal("targetio_o[3]", 8'(target_out[3]), 8'(uart_tx));
         check_equal("uart_rx_o", 8'(uart_rx), 8'(target_in[2]));  // gpio3 beats gpio4
      end
      write_checked(`CW_ADDR_IOROUTE + 8'd2, 8'h00);
      write_checked(`CW_ADDR_IOROUTE + 8'd3, 8'h01);
      check_equal("uart_rx_o", 8'(uart_rx), 8'h01);  // idle high with nothing routed
      write_checked(`CW_ADDR_IOROUTE + 8'd0, 8'hC0);  // drive level 1
      check_equal("targetio_o[0]", 8'(target_out[0]), 8'h01);
      check_equal("targetio_oe_o[0]", 8'(target_oe[0]), 8'h01);
      write_checked(`CW_ADDR_IOROUTE + 8'd0, 8'h80);  // drive level 0
      check_equal("targetio_o[0]", 8'(target_out[0]), 8'h00);
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h02);  // power off releases all
      check_equal("targetio_oe_o", 8'(target_oe), 8'h00);
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h00);

      // open collector on gpio3
      write_checked(`CW_ADDR_IOROUTE + 8'd2, 8'h10);
      for (int k = 0; k < 2; k++) begin
         @(negedge clk_usb);
         uart_tx = k[0];
         #1;
         check_equal("targetio_oe_o[2]", 8'(target_oe[2]), 8'(!uart_tx));
         if (!uart_tx)
            check_equal("targetio_o[2]", 8'(target_out[2]), 8'h00);
      end

      // userio direction with each mode set on top of the lower ones
      @(negedge clk_usb);
      trace_dir = 8'($urandom);
      write_checked(`CW_ADDR_USERIO_DEBUG, 8'h04);  // swd bit without target debug
      check_equal("userio_dir_o", userio_dir, reg_dir);
      write_checked(`CW_ADDR_USERIO_DEBUG, 8'h02);
      check_equal("userio_dir_o", userio_dir, 8'hE0);  // jtag
      write_checked(`CW_ADDR_USERIO_DEBUG, 8'h06);
      for (int k = 0; k < 2; k++) begin
         @(negedge clk_usb);
         userio_clk = k[0];
         #1;
         check_equal("userio_dir_o", userio_dir, userio_clk ? 8'h60 : 8'h20);
      end
      write_checked(`CW_ADDR_USERIO_DEBUG, 8'h07);
      check_equal("userio_dir_o", userio_dir, 8'hFF);  // fpga debug
      @(negedge clk_usb);
      trace_en = 1'b1;
      #1;
      check_equal("userio_dir_o", userio_dir, trace_dir);

      // fast start follows the power bit one cycle after the write
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h04);
      check_equal("targetpower_off_o", 8'(power_off), 8'h00);
      for (int k = 0; k < 8; k++) begin
         pwr = !k[0];  // every second write turns power back on
         write_checked(`CW_ADDR_IOROUTE + 8'd5, {5'b00000, 1'b1, pwr, 1'b0});
         check_equal("targetpower_off_o", 8'(power_off), 8'(pwr));
      end

      // soft start with a short ramp
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h02);
      check_equal("targetpower_off_o", 8'(power_off), 8'h01);
      for (int i = 0; i < 8; i++)
         write_checked(`CW_ADDR_SOFTPOWER + 8'(i), ramp_settings[8*i +: 8]);
      write_checked(`CW_ADDR_IOROUTE + 8'd5, 8'h00);
      saw_high = 1'b0;
      for (int c = 0; c < ramp_bound + 20; c++) begin
         if (c > 0 && power_off)
            saw_high = 1'b1;  // pwm pulses after the power-on edge cycle
         if (c >= ramp_bound)
            check_equal("targetpower_off_o", 8'(power_off), 8'h00);  // ramp over
         @(negedge clk_usb);
      end
      assert (saw_high) else report_failure("soft-start ramp never pulsed target power off");

      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/cw_io_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cw_io_top (
   input  wire                          clk_usb,
   input  wire                          reset,
   // apb register port
   input  wire                          psel_i,
   input  wire                          penable_i,
   input  wire                          pwrite_i,
   input  wire cw_io_pkg::apb_addr_t    paddr_i,
   input  wire cw_io_pkg::apb_data_t    pwdata_i,
   output cw_io_pkg::apb_data_t         prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   // target side
   input  wire cw_io_pkg::targetio_t    targetio_i,
   output cw_io_pkg::targetio_t         targetio_o,
   output cw_io_pkg::targetio_t         targetio_oe_o,
   input  wire [3:0]                    target_misc_i,
   input  wire                          uart_tx_i,
   output logic                         uart_rx_o,
   output logic                         targetpower_off_o,
   // user header
   input  wire cw_io_pkg::userio_t      userio_d_i,
   input  wire                          userio_clk_i,
   input  wire                          trace_en_i,
   input  wire cw_io_pkg::userio_t      trace_dir_i,
   output cw_io_pkg::userio_t           userio_dir_o,
   output cw_io_pkg::userio_t           userio_drive_data_o
);

   cw_io_pkg::route_cfg_t     route_cfg;
   cw_io_pkg::softpower_cfg_t softpower_cfg;
   cw_io_pkg::userio_ctrl_t   userio_ctrl;

   cw_io_regs u_regs (
      .clk_usb             (clk_usb),
      .reset               (reset),
      .psel_i              (psel_i),
      .penable_i           (penable_i),
      .pwrite_i            (pwrite_i),
      .paddr_i             (paddr_i),
      .pwdata_i            (pwdata_i),
      .prdata_o            (prdata_o),
      .pready_o            (pready_o),
      .pslverr_o           (pslverr_o),
      .targetio_i          (targetio_i),     // sampled raw pad levels
      .target_misc_i       (target_misc_i),
      .userio_d_i          (userio_d_i),
      .userio_clk_i        (userio_clk_i),
      .route_cfg_o         (route_cfg),
      .softpower_cfg_o     (softpower_cfg),
      .userio_ctrl_o       (userio_ctrl),
      .userio_drive_data_o (userio_drive_data_o)
   );

   softpower_ramp u_ramp (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .cfg_i             (softpower_cfg),
      .targetpower_off_o (targetpower_off_o)
   );

   target_io_router u_router (
      .route_cfg_i   (route_cfg),
      .userio_ctrl_i (userio_ctrl),
      .targetio_i    (targetio_i),
      .uart_tx_i     (uart_tx_i),
      .trace_en_i    (trace_en_i),
      .trace_dir_i   (trace_dir_i),
      .userio_clk_i  (userio_clk_i),
      .targetio_o    (targetio_o),
      .targetio_oe_o (targetio_oe_o),
      .uart_rx_o     (uart_rx_o),
      .userio_dir_o  (userio_dir_o)
   );

endmodule

`default_nettype wire

// ==== logic/target_io_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cw_io_consts.svh"

module target_io_router (
   input  wire cw_io_pkg::route_cfg_t    route_cfg_i,
   input  wire cw_io_pkg::userio_ctrl_t  userio_ctrl_i,
   input  wire cw_io_pkg::targetio_t     targetio_i,
   input  wire                           uart_tx_i,
   input  wire                           trace_en_i,
   input  wire cw_io_pkg::userio_t       trace_dir_i,
   input  wire                           userio_clk_i,
   output cw_io_pkg::targetio_t          targetio_o,
   output cw_io_pkg::targetio_t          targetio_oe_o,
   output logic                          uart_rx_o,
   output cw_io_pkg::userio_t            userio_dir_o
);

   // target pin drivers, first matching rule wins
   always_comb begin
      targetio_o    = '0;
      targetio_oe_o = '0;
      for (int i = 0; i < 4; i++) begin
         if (route_cfg_i.power_off) begin
            targetio_o[i]    = 1'b0;        // unpowered target, keep off the pins
            targetio_oe_o[i] = 1'b0;
         end else if (route_cfg_i.gpio[i].tx) begin
            targetio_o[i]    = uart_tx_i;
            targetio_oe_o[i] = 1'b1;
         end else if (i == 2 && route_cfg_i.gpio[i].oc) begin
            targetio_o[i]    = 1'b0;        // pull low only, pullup gives the high
            targetio_oe_o[i] = ~uart_tx_i;
         end else if (route_cfg_i.gpio[i].drive) begin
            targetio_o[i]    = route_cfg_i.gpio[i].level;
            targetio_oe_o[i] = 1'b1;
         end else begin
            targetio_o[i]    = 1'b0;        // released
            targetio_oe_o[i] = 1'b0;
         end
      end
   end

   // rx from the lowest pin with rx set, idle high when none
   always_comb begin
      uart_rx_o = 1'b1;
      for (int i = 3; i >= 0; i--) begin
         if (route_cfg_i.gpio[i].rx)
            uart_rx_o = targetio_i[i];      // later iterations are lower pins
      end
   end

   // user header direction, trace first then debug modes then register
   always_comb begin
      if (trace_en_i)
         userio_dir_o = trace_dir_i;
      else if (userio_ctrl_i.fpga_debug)
         userio_dir_o = '1;                 // whole header driven by fpga
      else if (userio_ctrl_i.target_debug && userio_ctrl_i.swd)
         userio_dir_o = userio_clk_i ? `CW_SWD_DIR_CLK_HIGH : `CW_SWD_DIR_CLK_LOW;  // swdio turns
      else if (userio_ctrl_i.target_debug)
         userio_dir_o = `CW_JTAG_DIR;       // tck, tms, tdi out
      else
         userio_dir_o = userio_ctrl_i.reg_dir;
   end

endmodule

`default_nettype wire

// ==== logic/softpower_ramp.sv ====
`timescale 1ns/1ps
`default_nettype none

module softpower_ramp (
   input  wire                             clk_usb,
   input  wire                             reset,
   input  wire cw_io_pkg::softpower_cfg_t  cfg_i,
   output logic                            targetpower_off_o
);

   cw_io_pkg::ramp_state_t  state_q;
   cw_io_pkg::pwm_count_t   pwm_cnt_q;     // position inside the pwm period
   cw_io_pkg::ramp_cycles_t wrap_cnt_q;    // finished periods in this phase
   cw_io_pkg::pwm_count_t   off_time;      // off-time of the current phase
   cw_io_pkg::ramp_cycles_t phase_cycles;  // periods in the current phase
   logic                    pwm_wrap;
   logic                    last_wrap;

   assign off_time     = (state_q == cw_io_pkg::RAMP_PHASE2) ? cfg_i.off_time2 : cfg_i.off_time1;
   assign phase_cycles = (state_q == cw_io_pkg::RAMP_PHASE2) ? cfg_i.cycles2 : cfg_i.cycles1;
   assign pwm_wrap     = pwm_cnt_q >= cfg_i.period;   // >= also recovers from a shrunk period
   assign last_wrap    = wrap_cnt_q == (phase_cycles - 8'd1);

   // state OFF doubles as the previous power_off level, so OFF with
   // power_off low is the power-on edge
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         state_q    <= cw_io_pkg::RAMP_ON;  // reset value of power_off is on
         pwm_cnt_q  <= '0;
         wrap_cnt_q <= '0;
      end else if (cfg_i.power_off) begin
         state_q    <= cw_io_pkg::RAMP_OFF;
         pwm_cnt_q  <= '0;
         wrap_cnt_q <= '0;
      end else begin
         case (state_q)
            cw_io_pkg::RAMP_OFF: begin
               pwm_cnt_q  <= '0;
               wrap_cnt_q <= '0;
               if (cfg_i.fast_start)
                  state_q <= cw_io_pkg::RAMP_ON;
               else if (cfg_i.cycles1 != 8'd0)
                  state_q <= cw_io_pkg::RAMP_PHASE1;
               else if (cfg_i.cycles2 != 8'd0)
                  state_q <= cw_io_pkg::RAMP_PHASE2;  // empty first phase
               else
                  state_q <= cw_io_pkg::RAMP_ON;
            end
            cw_io_pkg::RAMP_PHASE1, cw_io_pkg::RAMP_PHASE2: begin
               if (pwm_wrap) begin
                  pwm_cnt_q <= '0;
                  if (last_wrap) begin
                     wrap_cnt_q <= '0;
                     if (state_q == cw_io_pkg::RAMP_PHASE1 && cfg_i.cycles2 != 8'd0)
                        state_q <= cw_io_pkg::RAMP_PHASE2;
                     else
                        state_q <= cw_io_pkg::RAMP_ON;
                  end else begin
                     wrap_cnt_q <= wrap_cnt_q + 8'd1;
                  end
               end else begin
                  pwm_cnt_q <= pwm_cnt_q + 16'd1;
               end
            end
            default: begin  // RAMP_ON, counters parked
               pwm_cnt_q  <= '0;
               wrap_cnt_q <= '0;
            end
         endcase
      end
   end

   always_comb begin
      if (cfg_i.fast_start || cfg_i.power_off)
         targetpower_off_o = cfg_i.power_off;  // follows the register directly
      else begin
         case (state_q)
            cw_io_pkg::RAMP_OFF:    targetpower_off_o = 1'b1;  // edge cycle, still off
            cw_io_pkg::RAMP_PHASE1,
            cw_io_pkg::RAMP_PHASE2: targetpower_off_o = pwm_cnt_q < off_time;
            default:                targetpower_off_o = 1'b0;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== logic/cw_io_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cw_io_consts.svh"

module cw_io_regs (
   input  wire                          clk_usb,
   input  wire                          reset,
   input  wire                          psel_i,
   input  wire                          penable_i,
   input  wire                          pwrite_i,
   input  wire cw_io_pkg::apb_addr_t    paddr_i,
   input  wire cw_io_pkg::apb_data_t    pwdata_i,
   output cw_io_pkg::apb_data_t         prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   input  wire cw_io_pkg::targetio_t    targetio_i,
   input  wire [3:0]                    target_misc_i,   // isp pins, read back only
   input  wire cw_io_pkg::userio_t      userio_d_i,
   input  wire                          userio_clk_i,
   output cw_io_pkg::route_cfg_t        route_cfg_o,
   output cw_io_pkg::softpower_cfg_t    softpower_cfg_o,
   output cw_io_pkg::userio_ctrl_t      userio_ctrl_o,
   output cw_io_pkg::userio_t           userio_drive_data_o
);

   logic [63:0]          route_q;     // eight routing bytes
   logic [63:0]          soft_q;      // eight soft-power bytes
   cw_io_pkg::userio_t   driven_q;
   logic [2:0]           dbg_q;       // swd, target, fpga
   cw_io_pkg::userio_t   drive_data_q;

   // sampled pins
   cw_io_pkg::targetio_t pins_q;
   logic [3:0]           misc_q;
   cw_io_pkg::userio_t   userio_q;
   logic                 userio_clk_q;

   // offsets of the request into each multi-byte block
   cw_io_pkg::apb_addr_t off_route;
   cw_io_pkg::apb_addr_t off_ioread;
   cw_io_pkg::apb_addr_t off_uread;
   cw_io_pkg::apb_addr_t off_soft;

   logic hit_route, hit_ioread, hit_driven, hit_debug, hit_data, hit_uread, hit_soft;
   logic hit_any, hit_ro;
   logic access, wr_en;
   cw_io_pkg::apb_data_t rdata;

   assign off_route  = paddr_i - `CW_ADDR_IOROUTE;
   assign off_ioread = paddr_i - `CW_ADDR_IOREAD;
   assign off_uread  = paddr_i - `CW_ADDR_USERIO_READ;
   assign off_soft   = paddr_i - `CW_ADDR_SOFTPOWER;

   assign hit_route  = off_route  < `CW_IOROUTE_BYTES;
   assign hit_ioread = off_ioread < `CW_IOREAD_BYTES;
   assign hit_uread  = off_uread  < `CW_USERIO_READ_BYTES;
   assign hit_soft   = off_soft   < `CW_SOFTPOWER_BYTES;
   assign hit_driven = paddr_i == `CW_ADDR_USERIO_DRIVEN;
   assign hit_debug  = paddr_i == `CW_ADDR_USERIO_DEBUG;
   assign hit_data   = paddr_i == `CW_ADDR_USERIO_DATA;

   assign hit_ro  = hit_ioread | hit_uread;  // sampled pins cannot be written
   assign hit_any = hit_route | hit_ioread | hit_driven | hit_debug |
                    hit_data | hit_uread | hit_soft;

   assign access    = psel_i & penable_i;   // apb access phase, always one cycle
   assign wr_en     = access & pwrite_i & hit_any & ~hit_ro;
   assign pready_o  = 1'b1;                 // no wait states
   assign pslverr_o = access & (~hit_any | (pwrite_i & hit_ro));

   // register writes land on the edge that closes the access phase
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         route_q      <= `CW_IOROUTE_RESET;
         soft_q       <= `CW_SOFTPOWER_RESET;
         driven_q     <= '0;
         dbg_q        <= '0;
         drive_data_q <= '0;
      end else if (wr_en) begin
         if (hit_route)
            route_q[{off_route[2:0], 3'b000} +: 8] <= pwdata_i;
         if (hit_soft)
            soft_q[{off_soft[2:0], 3'b000} +: 8] <= pwdata_i;
         if (hit_driven)
            driven_q <= pwdata_i;
         if (hit_debug)
            dbg_q <= pwdata_i[2:0];  // upper bits ignored
         if (hit_data)
            drive_data_q <= pwdata_i;
      end
   end

   // pin levels, one cycle behind the pads
   always_ff @(posedge clk_usb) begin
      pins_q       <= targetio_i;
      misc_q       <= target_misc_i;
      userio_q     <= userio_d_i;
      userio_clk_q <= userio_clk_i;
   end

   always_comb begin
      rdata = '0;
      if (hit_route)
         rdata = route_q[{off_route[2:0], 3'b000} +: 8];
      else if (hit_ioread)
         rdata = off_ioread[0] ? {4'b0000, misc_q} : {4'b0000, pins_q};
      else if (hit_driven)
         rdata = driven_q;
      else if (hit_debug)
         rdata = {5'b00000, dbg_q};
      else if (hit_data)
         rdata = drive_data_q;
      else if (hit_uread)
         rdata = off_uread[0] ? {7'b0000000, userio_clk_q} : userio_q;
      else if (hit_soft)
         rdata = soft_q[{off_soft[2:0], 3'b000} +: 8];
   end

   assign prdata_o = access ? rdata : '0;  // bus idles at zero

   // unpack the stored bytes for the functional blocks
   always_comb begin
      route_cfg_o.power_off = route_q[`CW_IOROUTE_POWER_OFF];
      route_cfg_o.gpio      = route_q[31:0];  // gpio4 in the top byte

      softpower_cfg_o.cycles1    = soft_q[7:0];
      softpower_cfg_o.cycles2    = soft_q[15:8];
      softpower_cfg_o.period     = soft_q[31:16];
      softpower_cfg_o.off_time1  = soft_q[47:32];
      softpower_cfg_o.off_time2  = soft_q[63:48];
      softpower_cfg_o.power_off  = route_q[`CW_IOROUTE_POWER_OFF];
      softpower_cfg_o.fast_start = route_q[`CW_IOROUTE_FAST_START];

      userio_ctrl_o.reg_dir      = driven_q;
      userio_ctrl_o.fpga_debug   = dbg_q[`CW_DBG_FPGA];
      userio_ctrl_o.target_debug = dbg_q[`CW_DBG_TARGET];
      userio_ctrl_o.swd          = dbg_q[`CW_DBG_SWD];
   end

   assign userio_drive_data_o = drive_data_q;

endmodule

`default_nettype wire

// ==== logic/cw_io_pkg.sv ====
`default_nettype none

package cw_io_pkg;

   typedef logic [7:0]  apb_addr_t;     // byte address on the register port
   typedef logic [7:0]  apb_data_t;     // byte-wide data bus
   typedef logic [15:0] pwm_count_t;    // pwm period and off-times, in clk_usb cycles
   typedef logic [7:0]  ramp_cycles_t;  // pwm periods per ramp phase
   typedef logic [7:0]  userio_t;       // user header pins
   typedef logic [3:0]  targetio_t;     // bit 0 is gpio1

   // one routing byte, msb first
   typedef struct packed {
      logic       drive;    // bit 7, drive static level
      logic       level;    // bit 6
      logic       rsvd5;    // spare
      logic       oc;       // bit 4, open collector tx on gpio3
      logic [1:0] rsvd3_2;  // spare
      logic       rx;       // bit 1
      logic       tx;       // bit 0
   } gpio_route_t;

   typedef struct packed {
      logic                  power_off;  // releases every target pin
      gpio_route_t [3:0]     gpio;       // gpio[0] is gpio1
   } route_cfg_t;

   typedef struct packed {
      ramp_cycles_t cycles1;     // periods at off_time1
      ramp_cycles_t cycles2;     // periods at off_time2
      pwm_count_t   period;      // counter wraps after this value
      pwm_count_t   off_time1;
      pwm_count_t   off_time2;
      logic         power_off;   // requested target power state
      logic         fast_start;  // skip the ramp
   } softpower_cfg_t;

   typedef struct packed {
      userio_t reg_dir;       // direction when no debug mode owns the header
      logic    fpga_debug;
      logic    target_debug;
      logic    swd;           // swd instead of jtag when target_debug
   } userio_ctrl_t;

   // soft-start sequence
   typedef enum logic [1:0] {
      RAMP_OFF    = 2'd0,
      RAMP_PHASE1 = 2'd1,
      RAMP_PHASE2 = 2'd2,
      RAMP_ON     = 2'd3
   } ramp_state_t;

endpackage

`default_nettype wire

// ==== include/cw_io_consts.svh ====
`ifndef CW_IO_CONSTS_SVH
`define CW_IO_CONSTS_SVH

// register map, one apb address per byte
`define CW_ADDR_IOROUTE        8'h00  // 0x00-0x07 routing bytes
`define CW_ADDR_IOREAD         8'h08  // 0x08-0x09 sampled target pins, read only
`define CW_ADDR_USERIO_DRIVEN  8'h0A  // register-chosen userio direction
`define CW_ADDR_USERIO_DEBUG   8'h0B  // debug mode bits
`define CW_ADDR_USERIO_DATA    8'h0C  // userio drive data
`define CW_ADDR_USERIO_READ    8'h0D  // 0x0D-0x0E userio pins and userio clock, read only
`define CW_ADDR_SOFTPOWER      8'h10  // 0x10-0x17 soft-start settings

// byte counts of the multi-byte registers
`define CW_IOROUTE_BYTES       8'd8
`define CW_IOREAD_BYTES        8'd2
`define CW_USERIO_READ_BYTES   8'd2
`define CW_SOFTPOWER_BYTES     8'd8

// gpio1 drives tx, gpio2 takes rx, power on with soft-start
`define CW_IOROUTE_RESET       64'h0000_0000_0000_0201

// off_time2 0, off_time1 1995, period 2000, cycles2 0, cycles1 35
`define CW_SOFTPOWER_RESET     64'h0000_07CB_07D0_0023

// bit positions inside one gpio routing byte
`define CW_RT_TX               0
`define CW_RT_RX               1
`define CW_RT_OC               4      // gpio3 only
`define CW_RT_LEVEL            6
`define CW_RT_DRIVE            7

// power control bits of the routing register (extra byte 5)
`define CW_IOROUTE_POWER_OFF   41
`define CW_IOROUTE_FAST_START  42

// userio debug byte
`define CW_DBG_FPGA            0
`define CW_DBG_TARGET          1
`define CW_DBG_SWD             2

// fixed direction patterns of the debug modes
`define CW_SWD_DIR_CLK_LOW     8'h20
`define CW_SWD_DIR_CLK_HIGH    8'h60
`define CW_JTAG_DIR            8'hE0

`endif
